/* Makefile */
# Verilator build and run of the MAC slice testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := mac_unit_tb
FILELIST  := files.f
OBJDIR    := obj_dir
LOG       := sim.log
PASS_MSG  := Simulation passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || { echo "Pass message not found in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJDIR) $(LOG)

/* design/mac_decoder.sv */
/*
  Opcode decoder of the MAC slice.
  Checks the opcode, picks the accumulator source and steers the operands
  to either the integer/halfword datapath or the dot datapath.
  Purely combinational.
*/

`timescale 1ns/1ps
`default_nettype none

`include "mac_defs.svh"

module mac_decoder
  import mac_pkg::*;
(
  input  logic                  valid_i,
  input  mac_op_e               op_i,
  input  logic                  subword_i,
  input  logic                  signed_i,
  input  dot_sign_e             dot_sign_i,
  input  logic [`MAC_IMM_W-1:0] imm_i,
  input  logic [`MAC_XLEN-1:0]  op_a_i,
  input  logic [`MAC_XLEN-1:0]  op_b_i,
  input  logic [`MAC_XLEN-1:0]  op_c_i,
  input  logic                  use_acc_i,
  input  logic [`MAC_XLEN-1:0]  acc_value_i,

  output mac_op_e               operator_o,
  output logic                  short_subword_o,
  output logic                  short_signed_o,
  output dot_sign_e             dot_signed_o,
  output logic [`MAC_IMM_W-1:0] imm_o,
  output logic [`MAC_XLEN-1:0]  op_a_o,
  output logic [`MAC_XLEN-1:0]  op_b_o,
  output logic [`MAC_XLEN-1:0]  op_c_o,
  output logic [`MAC_XLEN-1:0]  dot_op_a_o,
  output logic [`MAC_XLEN-1:0]  dot_op_b_o,
  output logic [`MAC_XLEN-1:0]  dot_op_c_o,
  output logic                  issue_o,
  output logic                  illegal_o
);

  logic                 op_legal;
  logic                 op_is_dot;
  logic                 int_sel;
  logic                 dot_sel;
  logic [`MAC_XLEN-1:0] acc_src;

  // Legal set and datapath class
  always_comb
  begin
    op_legal  = 1'b1;
    op_is_dot = 1'b0;
    case (op_i)
      MAC_OP_MAC32, MAC_OP_MSU32: op_is_dot = 1'b0;
      MAC_OP_MULI, MAC_OP_MULIR:  op_is_dot = 1'b0;
      MAC_OP_DOT8, MAC_OP_DOT16:  op_is_dot = 1'b1;
      default:                    op_legal  = 1'b0;
    endcase
  end

  assign issue_o   = valid_i & op_legal;
  assign illegal_o = valid_i & ~op_legal;

  // Chained ops take the last written result instead of C
  assign acc_src = use_acc_i ? acc_value_i : op_c_i;

  // Operand isolation
  // Only the datapath of an issued op sees non-zero operands
  assign int_sel = issue_o & ~op_is_dot;
  assign dot_sel = issue_o & op_is_dot;

  assign op_a_o     = int_sel ? op_a_i  : '0;
  assign op_b_o     = int_sel ? op_b_i  : '0;
  assign op_c_o     = int_sel ? acc_src : '0;

  assign dot_op_a_o = dot_sel ? op_a_i  : '0;
  assign dot_op_b_o = dot_sel ? op_b_i  : '0;
  assign dot_op_c_o = dot_sel ? acc_src : '0;

  // Controls go straight to the MAC
  assign operator_o      = op_i;
  assign short_subword_o = subword_i;
  assign short_signed_o  = signed_i;
  assign dot_signed_o    = dot_sign_i;
  assign imm_o           = imm_i;

endmodule

`default_nettype wire

/* design/mac_defs.svh */
/*
  Width parameters of the MAC slice.
  Include this header in every RTL and testbench file that sizes a
  datapath, an immediate or an opcode field.
*/

`ifndef MAC_DEFS_SVH
`define MAC_DEFS_SVH

// Operand, accumulator and result width
`define MAC_XLEN 32

// Shift immediate of the halfword ops
// Wide enough to shift by any amount below MAC_XLEN
`define MAC_IMM_W 5

// Opcode field width
// Six legal operations, the two spare codes decode as illegal
`define MAC_OP_W 3

`endif

/* design/mac_pkg.sv */
/*
  Shared types of the MAC slice: opcodes and dot-product signedness.
  Import with a wildcard in the module header.
*/

`default_nettype none

`include "mac_defs.svh"

package mac_pkg;

  // Opcodes
  // Codes 6 and 7 have no name and are rejected by the decoder
  typedef enum logic [`MAC_OP_W-1:0] {
    MAC_OP_MAC32 = `MAC_OP_W'(0),
    MAC_OP_MSU32 = `MAC_OP_W'(1),
    MAC_OP_MULI  = `MAC_OP_W'(2),
    MAC_OP_MULIR = `MAC_OP_W'(3),
    MAC_OP_DOT8  = `MAC_OP_W'(4),
    MAC_OP_DOT16 = `MAC_OP_W'(5)
  } mac_op_e;

  // Dot product signedness
  // High bit is operand A, low bit is operand B
  typedef enum logic [1:0] {
    DOT_UU = 2'b00,
    DOT_US = 2'b01,
    DOT_SU = 2'b10,
    DOT_SS = 2'b11
  } dot_sign_e;

endpackage

`default_nettype wire

/* design/mac_unit_top.sv */
/*
  Top level of the MAC slice.
  Decoder and MAC form the combinational path, writeback adds the one
  register stage. Results appear one cycle after valid_i.
*/

`timescale 1ns/1ps
`default_nettype none

`include "mac_defs.svh"

module mac_unit_top
  import mac_pkg::*;
(
  input  logic                  clk,
  input  logic                  arst_n_i,

  input  logic                  valid_i,
  input  mac_op_e               op_i,
  input  logic                  subword_i,
  input  logic                  signed_i,
  input  dot_sign_e             dot_sign_i,
  input  logic [`MAC_IMM_W-1:0] imm_i,
  input  logic [`MAC_XLEN-1:0]  op_a_i,
  input  logic [`MAC_XLEN-1:0]  op_b_i,
  input  logic [`MAC_XLEN-1:0]  op_c_i,
  input  logic                  use_acc_i,

  output logic [`MAC_XLEN-1:0]  result_o,
  output logic                  valid_o,
  output logic                  illegal_o
);

  // Decoder to MAC
  mac_op_e               operator;
  logic                  short_subword;
  logic                  short_signed;
  dot_sign_e             dot_signed;
  logic [`MAC_IMM_W-1:0] imm;
  logic [`MAC_XLEN-1:0]  op_a;
  logic [`MAC_XLEN-1:0]  op_b;
  logic [`MAC_XLEN-1:0]  op_c;
  logic [`MAC_XLEN-1:0]  dot_op_a;
  logic [`MAC_XLEN-1:0]  dot_op_b;
  logic [`MAC_XLEN-1:0]  dot_op_c;

  // Decoder to writeback
  logic                  issue;
  logic                  illegal;

  // MAC to writeback, and the feedback path
  logic [`MAC_XLEN-1:0]  mac_result;
  logic [`MAC_XLEN-1:0]  acc_value;

  mac_decoder u_decoder (
    .valid_i         (valid_i),
    .op_i            (op_i),
    .subword_i       (subword_i),
    .signed_i        (signed_i),
    .dot_sign_i      (dot_sign_i),
    .imm_i           (imm_i),
    .op_a_i          (op_a_i),
    .op_b_i          (op_b_i),
    .op_c_i          (op_c_i),
    .use_acc_i       (use_acc_i),
    .acc_value_i     (acc_value),
    .operator_o      (operator),
    .short_subword_o (short_subword),
    .short_signed_o  (short_signed),
    .dot_signed_o    (dot_signed),
    .imm_o           (imm),
    .op_a_o          (op_a),
    .op_b_o          (op_b),
    .op_c_o          (op_c),
    .dot_op_a_o      (dot_op_a),
    .dot_op_b_o      (dot_op_b),
    .dot_op_c_o      (dot_op_c),
    .issue_o         (issue),
    .illegal_o       (illegal)
  );

  subword_mac u_mac (
    .operator_i      (operator),
    .short_subword_i (short_subword),
    .short_signed_i  (short_signed),
    .imm_i           (imm),
    .op_a_i          (op_a),
    .op_b_i          (op_b),
    .op_c_i          (op_c),
    .dot_signed_i    (dot_signed),
    .dot_op_a_i      (dot_op_a),
    .dot_op_b_i      (dot_op_b),
    .dot_op_c_i      (dot_op_c),
    .result_o        (mac_result)
  );

  mac_writeback u_writeback (
    .clk             (clk),
    .arst_n_i        (arst_n_i),
    .issue_i         (issue),
    .illegal_i       (illegal),
    .mac_result_i    (mac_result),
    .result_o        (result_o),
    .acc_value_o     (acc_value),
    .valid_o         (valid_o),
    .illegal_o       (illegal_o)
  );

endmodule

`default_nettype wire

/* design/mac_writeback.sv */
/*
  Writeback stage of the MAC slice.
  Registers the MAC result on issue and turns issue and illegal into
  one-cycle pulses. The held result doubles as the chained accumulator.
*/

`timescale 1ns/1ps
`default_nettype none

`include "mac_defs.svh"

module mac_writeback
  import mac_pkg::*;
(
  input  logic                 clk,
  input  logic                 arst_n_i,
  input  logic                 issue_i,
  input  logic                 illegal_i,
  input  logic [`MAC_XLEN-1:0] mac_result_i,

  output logic [`MAC_XLEN-1:0] result_o,
  output logic [`MAC_XLEN-1:0] acc_value_o,
  output logic                 valid_o,
  output logic                 illegal_o
);

  logic [`MAC_XLEN-1:0] result_q;
  logic                 valid_q;
  logic                 illegal_q;

  // Status pulses, high for exactly one cycle per request
  always_ff @(posedge clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      valid_q   <= 1'b0;
      illegal_q <= 1'b0;
    end
    else
    begin
      valid_q   <= issue_i;
      illegal_q <= illegal_i;
    end
  end

  // Result holds across idle and illegal cycles
  // Cleared so the first chained op starts from zero
  always_ff @(posedge clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
      result_q <= '0;
    else if (issue_i)
      result_q <= mac_result_i;
  end

  assign result_o    = result_q;
  // Same register, back to the decoder
  assign acc_value_o = result_q;
  assign valid_o     = valid_q;
  assign illegal_o   = illegal_q;

endmodule

`default_nettype wire

/* design/subword_mac.sv */
/*
  Combinational subword MAC.
  Integer MAC/MSU, halfword multiply with shift and optional rounding,
  and 8-bit and 16-bit dot products. The opcode selects the result,
  unused encodings give zero.
*/

`timescale 1ns/1ps
`default_nettype none

`include "mac_defs.svh"

module subword_mac
  import mac_pkg::*;
(
  input  mac_op_e               operator_i,

  // Integer and halfword path
  input  logic                  short_subword_i,
  input  logic                  short_signed_i,
  input  logic [`MAC_IMM_W-1:0] imm_i,
  input  logic [`MAC_XLEN-1:0]  op_a_i,
  input  logic [`MAC_XLEN-1:0]  op_b_i,
  input  logic [`MAC_XLEN-1:0]  op_c_i,

  // Dot path
  input  dot_sign_e             dot_signed_i,
  input  logic [`MAC_XLEN-1:0]  dot_op_a_i,
  input  logic [`MAC_XLEN-1:0]  dot_op_b_i,
  input  logic [`MAC_XLEN-1:0]  dot_op_c_i,

  output logic [`MAC_XLEN-1:0]  result_o
);

  localparam int HALF_W = `MAC_XLEN / 2;
  localparam int BYTE_W = `MAC_XLEN / 4;

  //////////////////////////////////////////////////////////////////////
  // Integer multiplier
  //////////////////////////////////////////////////////////////////////

  logic                 int_is_msu;
  logic [`MAC_XLEN-1:0] int_op_a;
  logic [`MAC_XLEN-1:0] int_corr;
  logic [`MAC_XLEN-1:0] int_result;

  // MSU as C + (~A)*B + B
  // (~A)*B + B equals -A*B modulo 2^XLEN
  assign int_is_msu = (operator_i == MAC_OP_MSU32);
  assign int_op_a   = op_a_i ^ {`MAC_XLEN{int_is_msu}};
  assign int_corr   = op_b_i & {`MAC_XLEN{int_is_msu}};

  // Low word only, signedness does not matter here
  assign int_result = op_c_i + int_corr + int_op_a * op_b_i;

  //////////////////////////////////////////////////////////////////////
  // Halfword multiplier
  //////////////////////////////////////////////////////////////////////

  logic [HALF_W:0]              short_op_a;
  logic [HALF_W:0]              short_op_b;
  logic [`MAC_XLEN-1:0]         short_round_pos;
  logic [`MAC_XLEN-1:0]         short_round;
  logic [`MAC_XLEN-1:0]         short_mac;
  logic [`MAC_XLEN:0]           short_ext;
  logic signed [`MAC_XLEN:0]    short_shifted;
  logic [`MAC_XLEN-1:0]         short_result;

  // Halfword pick
  assign short_op_a[HALF_W-1:0] = short_subword_i ? op_a_i[`MAC_XLEN-1:HALF_W]
                                                  : op_a_i[HALF_W-1:0];
  assign short_op_b[HALF_W-1:0] = short_subword_i ? op_b_i[`MAC_XLEN-1:HALF_W]
                                                  : op_b_i[HALF_W-1:0];

  // Extra top bit is the sign, or zero when unsigned
  assign short_op_a[HALF_W] = short_signed_i & short_op_a[HALF_W-1];
  assign short_op_b[HALF_W] = short_signed_i & short_op_b[HALF_W-1];

  // Half an LSB of the shifted result, MULIR only
  // Zero when imm is zero
  assign short_round_pos = {{(`MAC_XLEN-1){1'b0}}, 1'b1} << imm_i;
  assign short_round     = (operator_i == MAC_OP_MULIR)
                           ? {1'b0, short_round_pos[`MAC_XLEN-1:1]} : '0;

  // All terms signed, so the 17-bit operands sign extend
  assign short_mac = $signed(op_c_i) + $signed(short_op_a) * $signed(short_op_b)
                     + $signed(short_round);

  // Extra top bit makes the shift logical for unsigned ops
  assign short_ext     = {short_signed_i & short_mac[`MAC_XLEN-1], short_mac};
  assign short_shifted = $signed(short_ext) >>> imm_i;
  assign short_result  = short_shifted[`MAC_XLEN-1:0];

  //////////////////////////////////////////////////////////////////////
  // Dot products
  //////////////////////////////////////////////////////////////////////

  logic                         dot_a_signed;
  logic                         dot_b_signed;

  logic [3:0][BYTE_W:0]         dot_char_op_a;
  logic [3:0][BYTE_W:0]         dot_char_op_b;
  logic [3:0][2*BYTE_W+1:0]     dot_char_mul;
  logic [`MAC_XLEN-1:0]         dot_char_result;

  logic [1:0][HALF_W:0]         dot_short_op_a;
  logic [1:0][HALF_W:0]         dot_short_op_b;
  logic [1:0][2*HALF_W+1:0]     dot_short_mul;
  logic [`MAC_XLEN-1:0]         dot_short_result;

  assign dot_a_signed = (dot_signed_i == DOT_SU) || (dot_signed_i == DOT_SS);
  assign dot_b_signed = (dot_signed_i == DOT_US) || (dot_signed_i == DOT_SS);

  // Four byte lanes, C as the starting sum
  always_comb
  begin
    dot_char_result = dot_op_c_i;
    for (int i = 0; i < 4; i++)
    begin
      dot_char_op_a[i] = {dot_a_signed & dot_op_a_i[BYTE_W*i+BYTE_W-1],
                          dot_op_a_i[BYTE_W*i +: BYTE_W]};
      dot_char_op_b[i] = {dot_b_signed & dot_op_b_i[BYTE_W*i+BYTE_W-1],
                          dot_op_b_i[BYTE_W*i +: BYTE_W]};
      dot_char_mul[i]  = $signed(dot_char_op_a[i]) * $signed(dot_char_op_b[i]);
      // Lane product sign extended to the full word
      dot_char_result  = dot_char_result
                         + {{(`MAC_XLEN-2*BYTE_W-2){dot_char_mul[i][2*BYTE_W+1]}},
                            dot_char_mul[i]};
    end
  end

  // Two halfword lanes
  always_comb
  begin
    dot_short_result = dot_op_c_i;
    for (int i = 0; i < 2; i++)
    begin
      dot_short_op_a[i] = {dot_a_signed & dot_op_a_i[HALF_W*i+HALF_W-1],
                           dot_op_a_i[HALF_W*i +: HALF_W]};
      dot_short_op_b[i] = {dot_b_signed & dot_op_b_i[HALF_W*i+HALF_W-1],
                           dot_op_b_i[HALF_W*i +: HALF_W]};
      dot_short_mul[i]  = $signed(dot_short_op_a[i]) * $signed(dot_short_op_b[i]);
      // Product wider than the word, low bits are enough
      dot_short_result  = dot_short_result + dot_short_mul[i][`MAC_XLEN-1:0];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Result mux
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    unique case (operator_i)
      MAC_OP_MAC32, MAC_OP_MSU32: result_o = int_result;
      MAC_OP_MULI, MAC_OP_MULIR:  result_o = short_result;
      MAC_OP_DOT8:                result_o = dot_char_result;
      MAC_OP_DOT16:               result_o = dot_short_result;
      // Spare encodings
      default:                    result_o = '0;
    endcase
  end

endmodule

`default_nettype wire

/* files.f */
+incdir+design
design/mac_pkg.sv
design/mac_decoder.sv
design/subword_mac.sv
design/mac_writeback.sv
design/mac_unit_top.sv
verif/mac_unit_properties.sv
verif/mac_unit_tb.sv

/* verif/mac_unit_properties.sv */
/*
  Concurrent checks on the status outputs of the MAC slice.
  Bound to mac_unit_top from the testbench.
*/

`timescale 1ns/1ps
`default_nettype none

`include "mac_defs.svh"

module mac_unit_properties
  import mac_pkg::*;
(
  input logic    clk,
  input logic    arst_n_i,
  input logic    valid_i,
  input mac_op_e op_i,
  input logic    valid_o,
  input logic    illegal_o
);

  logic op_legal;

  assign op_legal = op_i inside {MAC_OP_MAC32, MAC_OP_MSU32, MAC_OP_MULI,
                                 MAC_OP_MULIR, MAC_OP_DOT8, MAC_OP_DOT16};

  // A request is either written back or rejected, never both
  valid_illegal_exclusive: assert property (@(posedge clk) disable iff (!arst_n_i)
    !(valid_o && illegal_o))
    else $error("valid_o and illegal_o are high in the same cycle");

  // Legal request gives a valid pulse one cycle later
  valid_after_issue: assert property (@(posedge clk) disable iff (!arst_n_i)
    (valid_i && op_legal) |=> valid_o)
    else $error("valid_o missing one cycle after a legal request");

  // Status quiet in reset
  quiet_in_reset: assert property (@(posedge clk)
    !arst_n_i |-> (!valid_o && !illegal_o))
    else $error("status output high while reset is active");

endmodule

`default_nettype wire

/* verif/mac_unit_tb.sv */
/*
  Directed testbench of the MAC slice.
  Each test task drives operations on the falling edge and checks the
  registered outputs one cycle later against a behavioral model.
*/

`timescale 1ns/1ps
`default_nettype none

`include "mac_defs.svh"

module mac_unit_tb
  import mac_pkg::*;
;

  localparam int CLK_PERIOD = 20;
  // Reset check, 16 integer, 16 halfword, 16 dot, 3 chained, 2 illegal
  localparam int NUM_OPS    = 54;
  localparam int TIMEOUT_NS = (NUM_OPS + 20) * CLK_PERIOD;

  logic                  clk;
  logic                  arst_n_i;
  logic                  valid_i;
  mac_op_e               op_i;
  logic                  subword_i;
  logic                  signed_i;
  dot_sign_e             dot_sign_i;
  logic [`MAC_IMM_W-1:0] imm_i;
  logic [`MAC_XLEN-1:0]  op_a_i;
  logic [`MAC_XLEN-1:0]  op_b_i;
  logic [`MAC_XLEN-1:0]  op_c_i;
  logic                  use_acc_i;
  logic [`MAC_XLEN-1:0]  result_o;
  logic                  valid_o;
  logic                  illegal_o;

  int                    errors;
  // Model copy of the writeback register
  logic [`MAC_XLEN-1:0]  last_result;

  mac_unit_top DUT (
    .clk        (clk),
    .arst_n_i   (arst_n_i),
    .valid_i    (valid_i),
    .op_i       (op_i),
    .subword_i  (subword_i),
    .signed_i   (signed_i),
    .dot_sign_i (dot_sign_i),
    .imm_i      (imm_i),
    .op_a_i     (op_a_i),
    .op_b_i     (op_b_i),
    .op_c_i     (op_c_i),
    .use_acc_i  (use_acc_i),
    .result_o   (result_o),
    .valid_o    (valid_o),
    .illegal_o  (illegal_o)
  );

  bind mac_unit_top mac_unit_properties u_properties (
    .clk       (clk),
    .arst_n_i  (arst_n_i),
    .valid_i   (valid_i),
    .op_i      (op_i),
    .valid_o   (valid_o),
    .illegal_o (illegal_o)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  // Low w bits of v, zero or sign extended
  function automatic longint lane_value(input logic [`MAC_XLEN-1:0] v, input int w,
                                        input logic sgn);
    longint val;
    val = longint'(v) & ((longint'(1) << w) - 1);
    if (sgn && v[w-1])
      val = val - (longint'(1) << w);
    return val;
  endfunction

  function automatic logic [`MAC_XLEN-1:0] expected_mac(
    input mac_op_e op, input logic sub, input logic sgn, input dot_sign_e ds,
    input logic [`MAC_IMM_W-1:0] imm, input logic [`MAC_XLEN-1:0] a,
    input logic [`MAC_XLEN-1:0] b, input logic [`MAC_XLEN-1:0] c);
    longint               sum;
    logic [`MAC_XLEN-1:0] word;
    int                   w;
    case (op)
      MAC_OP_MAC32: return c + a * b;
      MAC_OP_MSU32: return c - a * b;
      MAC_OP_MULI, MAC_OP_MULIR:
      begin
        sum = longint'(c) + lane_value(sub ? a >> 16 : a, 16, sgn)
                          * lane_value(sub ? b >> 16 : b, 16, sgn);
        // Round to nearest adds half of the dropped LSB
        if (op == MAC_OP_MULIR && imm != 0)
          sum = sum + (longint'(1) << (imm - 1));
        word = sum[`MAC_XLEN-1:0];
        if (sgn)
          word = $signed(word) >>> imm;
        else
          word = word >> imm;
        return word;
      end
      MAC_OP_DOT8, MAC_OP_DOT16:
      begin
        w   = (op == MAC_OP_DOT8) ? 8 : 16;
        sum = longint'(c);
        for (int i = 0; i < `MAC_XLEN / w; i++)
          sum = sum + lane_value(a >> (i * w), w, ds[1]) * lane_value(b >> (i * w), w, ds[0]);
        return sum[`MAC_XLEN-1:0];
      end
      default: return '0;
    endcase
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Compare tasks and driver
  //////////////////////////////////////////////////////////////////////

  task automatic check_result(input logic [`MAC_XLEN-1:0] got, input logic [`MAC_XLEN-1:0] exp,
                              input string what);
    if (got !== exp)
    begin
      errors++;
      $display("Mismatch at %0t ns: %s result_o %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_flags(input logic got_valid, input logic got_illegal,
                             input logic exp_valid, input logic exp_illegal, input string what);
    if (got_valid !== exp_valid || got_illegal !== exp_illegal)
    begin
      errors++;
      $display("Mismatch at %0t ns: %s valid_o/illegal_o %b%b, expected %b%b",
               $time, what, got_valid, got_illegal, exp_valid, exp_illegal);
    end
  endtask

  // Called on a falling edge, returns on the next one after checking
  task automatic issue_op(input mac_op_e op, input logic sub, input logic sgn,
                          input dot_sign_e ds, input logic [`MAC_IMM_W-1:0] imm,
                          input logic [`MAC_XLEN-1:0] a, input logic [`MAC_XLEN-1:0] b,
                          input logic [`MAC_XLEN-1:0] c, input logic use_acc,
                          input string what);
    logic                 legal;
    logic [`MAC_XLEN-1:0] exp;
    legal = op inside {MAC_OP_MAC32, MAC_OP_MSU32, MAC_OP_MULI,
                       MAC_OP_MULIR, MAC_OP_DOT8, MAC_OP_DOT16};
    // Illegal ops leave the register alone
    exp = legal ? expected_mac(op, sub, sgn, ds, imm, a, b, use_acc ? last_result : c)
                : last_result;
    valid_i    = 1'b1;
    op_i       = op;
    subword_i  = sub;
    signed_i   = sgn;
    dot_sign_i = ds;
    imm_i      = imm;
    op_a_i     = a;
    op_b_i     = b;
    op_c_i     = c;
    use_acc_i  = use_acc;
    @(negedge clk);
    valid_i = 1'b0;
    check_flags(valid_o, illegal_o, legal, !legal, what);
    check_result(result_o, exp, what);
    last_result = exp;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_reset_state();
    check_flags(valid_o, illegal_o, 1'b0, 1'b0, "reset");
    check_result(result_o, '0, "reset");
    last_result = '0;
    @(negedge clk);
  endtask

  task automatic test_integer();
    repeat (8)
    begin
      issue_op(MAC_OP_MAC32, 1'b0, 1'b0, DOT_UU, '0, $urandom, $urandom, $urandom, 1'b0, "MAC32");
      issue_op(MAC_OP_MSU32, 1'b0, 1'b0, DOT_UU, '0, $urandom, $urandom, $urandom, 1'b0, "MSU32");
    end
  endtask

  task automatic test_halfword();
    mac_op_e op;
    for (int k = 0; k < 2; k++)
      for (int s = 0; s < 4; s++)
        repeat (2)
        begin
          op = (k == 0) ? MAC_OP_MULI : MAC_OP_MULIR;
          issue_op(op, s[1], s[0], DOT_UU, `MAC_IMM_W'($urandom), $urandom, $urandom,
                   $urandom, 1'b0, "halfword");
        end
  endtask

  task automatic test_dot();
    mac_op_e op;
    for (int k = 0; k < 2; k++)
      for (int s = 0; s < 4; s++)
        repeat (2)
        begin
          op = (k == 0) ? MAC_OP_DOT8 : MAC_OP_DOT16;
          issue_op(op, 1'b0, 1'b0, dot_sign_e'(s), '0, $urandom, $urandom, $urandom,
                   1'b0, "dot");
        end
  endtask

  // Second and third op accumulate onto the result in flight
  task automatic test_chain();
    issue_op(MAC_OP_MAC32, 1'b0, 1'b0, DOT_UU, '0, $urandom, $urandom, $urandom, 1'b0, "chain 1");
    issue_op(MAC_OP_MAC32, 1'b0, 1'b0, DOT_UU, '0, $urandom, $urandom, $urandom, 1'b1, "chain 2");
    issue_op(MAC_OP_MAC32, 1'b0, 1'b0, DOT_UU, '0, $urandom, $urandom, $urandom, 1'b1, "chain 3");
  endtask

  task automatic test_illegal();
    issue_op(mac_op_e'(`MAC_OP_W'(6)), 1'b0, 1'b0, DOT_UU, '0, $urandom, $urandom, $urandom,
             1'b0, "illegal 6");
    issue_op(mac_op_e'(`MAC_OP_W'(7)), 1'b0, 1'b0, DOT_UU, '0, $urandom, $urandom, $urandom,
             1'b0, "illegal 7");
  endtask

  initial
  begin
    #(TIMEOUT_NS);
    $display("Timeout: tests did not finish within %0d ns", TIMEOUT_NS);
    $display("Simulation failed");
    $finish;
  end

  initial
  begin
    errors      = 0;
    last_result = '0;
    void'($urandom(32'h5947b702));
    arst_n_i    = 1'b0;
    valid_i     = 1'b0;
    op_i        = MAC_OP_MAC32;
    subword_i   = 1'b0;
    signed_i    = 1'b0;
    dot_sign_i  = DOT_UU;
    imm_i       = '0;
    op_a_i      = '0;
    op_b_i      = '0;
    op_c_i      = '0;
    use_acc_i   = 1'b0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    arst_n_i = 1'b1;
    test_reset_state();
    test_integer();
    test_halfword();
    test_dot();
    test_chain();
    test_illegal();
    $display("Errors: %0d", errors);
    if (errors == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire
